// File: design/intOpPkg.sv
// ============================================================
// Operation encoding, execution states and data widths
// Widths are fixed here and shared by every block
// Tag space of 16 must exceed the number of outstanding ops
// ============================================================
package intOpPkg;

    // Register and address width
    localparam int dataWidth = 32;

    // 32 physical registers
    localparam int regNumWidth = 5;

    // 16 active-list tags
    localparam int tagWidth = 4;

    // ALU ops combine both sources
    // BR compares for equality and targets pc + imm
    // RIJ targets src1 + imm and links pc + 4
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        XOR = 3'd3,
        BR  = 3'd4,
        RIJ = 3'd5
    } IntOpType;

    // Per-tag completion state
    typedef enum logic [1:0] {
        NOT_FINISHED     = 2'd0,
        SUCCESS          = 2'd1,
        REFETCH_NEXT     = 2'd2,
        FAULT_MISALIGNED = 2'd3
    } ExecState;

endpackage

// File: design/intPipePkg.sv
// ============================================================
// Payload structs passed between the pipeline stages
// All structs are packed so they travel on plain ports
// ============================================================
package intPipePkg;

    // Micro-op as issued by the scheduler
    typedef struct packed {
        intOpPkg::IntOpType opType;
        logic [intOpPkg::tagWidth-1:0] tag;
        logic [intOpPkg::dataWidth-1:0] pc;
        logic [intOpPkg::regNumWidth-1:0] src1Num;
        logic [intOpPkg::regNumWidth-1:0] src2Num;
        logic [intOpPkg::regNumWidth-1:0] dstNum;
        logic writeReg;
        logic [intOpPkg::dataWidth-1:0] imm;
        // Prediction from the fetch side
        logic predTaken;
        // Wakeup hint, low means the op must replay
        logic operandsReady;
    } IntIssueOp;

    // Resolved branch sent to the fetch side
    typedef struct packed {
        logic valid;
        logic taken;
        logic [intOpPkg::dataWidth-1:0] nextAddr;
        logic misPred;
    } BranchResult;

    // Execution register contents
    typedef struct packed {
        logic valid;
        IntIssueOp op;
        logic [intOpPkg::dataWidth-1:0] dataOut;
        logic dataValid;
        BranchResult brResult;
    } ExecResult;

endpackage

// File: design/completionIf.sv
// ============================================================
// Completion write from the write stage to the table
// Table samples the fields on the edge where write is high
// pc carries the pc of the completing op
// ============================================================
interface completionIf;
    import intOpPkg::*;

    logic write;
    logic [tagWidth-1:0] tag;
    ExecState state;
    logic [dataWidth-1:0] pc;
    // Only meaningful with FAULT_MISALIGNED
    logic [dataWidth-1:0] faultAddr;

    modport writer (
        output write,
        output tag,
        output state,
        output pc,
        output faultAddr
    );

    modport tableSide (
        input write,
        input tag,
        input state,
        input pc,
        input faultAddr
    );

endinterface

// File: design/intExecStage.sv
// ============================================================
// Issue queue, operand read with forwarding, ALU and branches
// Queue has no full check, the scheduler credits bound it
// BR never writes a register even if writeReg is set
// ============================================================
module intExecStage #(
    parameter int queueDepth = 4
) (
    input  logic ctrl,
    input  logic rst,
    input  logic stall,
    input  logic issueValid,
    input  intPipePkg::IntIssueOp issueOp,
    output logic [intOpPkg::regNumWidth-1:0] rdNum1,
    output logic [intOpPkg::regNumWidth-1:0] rdNum2,
    input  logic [intOpPkg::dataWidth-1:0] rdData1,
    input  logic [intOpPkg::dataWidth-1:0] rdData2,
    input  logic wbEn,
    input  logic [intOpPkg::regNumWidth-1:0] wbNum,
    input  logic [intOpPkg::dataWidth-1:0] wbData,
    output intPipePkg::ExecResult execOut
);
    import intOpPkg::*;
    import intPipePkg::*;

    localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntWidth = $clog2(queueDepth + 1);

    IntIssueOp queue [queueDepth];
    logic [ptrWidth-1:0] headPtr;
    logic [ptrWidth-1:0] tailPtr;
    logic [cntWidth-1:0] count;
    logic pop;
    IntIssueOp headOp;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] linkAddr;
    logic execFwdOk;
    ExecResult nextResult;

    // Circular increment for any depth
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(queueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign pop = !stall && (count != '0);

    always_ff @(posedge ctrl) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (issueValid) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (pop) begin
                headPtr <= nextPtr(headPtr);
            end
            count <= count + cntWidth'(issueValid) - cntWidth'(pop);
        end
    end

    always_ff @(posedge ctrl) begin
        if (issueValid) begin
            queue[tailPtr] <= issueOp;
        end
    end

    always_comb begin
        headOp = queue[headPtr];
        rdNum1 = headOp.src1Num;
        rdNum2 = headOp.src2Num;
        linkAddr = headOp.pc + dataWidth'(4);

        // Forwarding priority rises from register file to write port to exec register
        execFwdOk = execOut.valid && execOut.dataValid && execOut.op.writeReg;
        opA = rdData1;
        if (wbEn && (wbNum == headOp.src1Num)) begin
            opA = wbData;
        end
        if (execFwdOk && (execOut.op.dstNum == headOp.src1Num)) begin
            opA = execOut.dataOut;
        end
        opB = rdData2;
        if (wbEn && (wbNum == headOp.src2Num)) begin
            opB = wbData;
        end
        if (execFwdOk && (execOut.op.dstNum == headOp.src2Num)) begin
            opB = execOut.dataOut;
        end

        nextResult = '0;
        nextResult.valid = (count != '0);
        nextResult.op = headOp;
        nextResult.op.writeReg = headOp.writeReg && (headOp.opType != BR);
        nextResult.dataValid = headOp.operandsReady;
        case (headOp.opType)
            ADD: nextResult.dataOut = opA + opB;
            SUB: nextResult.dataOut = opA - opB;
            AND: nextResult.dataOut = opA & opB;
            XOR: nextResult.dataOut = opA ^ opB;
            BR: begin
                nextResult.dataOut = linkAddr;
                nextResult.brResult.valid = 1'b1;
                nextResult.brResult.taken = (opA == opB);
                nextResult.brResult.nextAddr =
                    (opA == opB) ? (headOp.pc + headOp.imm) : linkAddr;
            end
            RIJ: begin
                nextResult.dataOut = linkAddr;
                nextResult.brResult.valid = 1'b1;
                nextResult.brResult.taken = 1'b1;
                nextResult.brResult.nextAddr = opA + headOp.imm;
            end
            default: nextResult.dataOut = '0;
        endcase
        nextResult.brResult.misPred = nextResult.brResult.valid &&
            (nextResult.brResult.taken != headOp.predTaken);
    end

    always_ff @(posedge ctrl) begin
        if (rst) begin
            execOut.valid <= 1'b0;
        end else if (!stall) begin
            execOut <= nextResult;
        end
    end

endmodule

// File: design/intRegWriteStage.sv
// ============================================================
// Writeback stage with flush check and completion update
// Flush range is inclusive and wraps in circular tag order
// A credit returns for every op leaving, flushed ones too
// ============================================================
module intRegWriteStage (
    input  logic ctrl,
    input  logic rst,
    input  logic stall,
    input  intPipePkg::ExecResult execIn,
    input  logic flushActive,
    input  logic [intOpPkg::tagWidth-1:0] flushHead,
    input  logic [intOpPkg::tagWidth-1:0] flushTail,
    output logic regWe,
    output logic [intOpPkg::regNumWidth-1:0] regNum,
    output logic [intOpPkg::dataWidth-1:0] regData,
    output logic creditReturn,
    output intPipePkg::BranchResult brOut,
    output logic replayValid,
    output intPipePkg::IntIssueOp replayOp,
    completionIf.writer completion
);
    import intOpPkg::*;
    import intPipePkg::*;

    ExecResult pipeReg;
    logic flush;
    logic update;

    function automatic logic inFlushRange(
        input logic [tagWidth-1:0] tag,
        input logic [tagWidth-1:0] head,
        input logic [tagWidth-1:0] tail
    );
        if (head <= tail) begin
            return (tag >= head) && (tag <= tail);
        end
        return (tag >= head) || (tag <= tail);
    endfunction

    always_ff @(posedge ctrl) begin
        if (rst) begin
            pipeReg.valid <= 1'b0;
        end else if (!stall) begin
            pipeReg <= execIn;
        end
    end

    always_comb begin
        flush = flushActive && inFlushRange(pipeReg.op.tag, flushHead, flushTail);
        update = !stall && pipeReg.valid && !flush;
        creditReturn = !stall && pipeReg.valid;

        regWe = update && pipeReg.dataValid && pipeReg.op.writeReg;
        regNum = pipeReg.op.dstNum;
        regData = pipeReg.dataOut;

        // Branch result goes out only for ops that really executed
        brOut = pipeReg.brResult;
        brOut.valid = pipeReg.brResult.valid && update && pipeReg.dataValid;

        completion.write = update;
        completion.tag = pipeReg.op.tag;
        completion.pc = pipeReg.op.pc;
        completion.faultAddr = '0;
        completion.state = NOT_FINISHED;
        if (update && pipeReg.dataValid) begin
            completion.state = pipeReg.brResult.misPred ? REFETCH_NEXT : SUCCESS;
        end
        // Misaligned target overrides a good finish
        if (brOut.valid && (brOut.nextAddr[1:0] != 2'b00)) begin
            completion.state = FAULT_MISALIGNED;
            completion.faultAddr = brOut.nextAddr;
        end

        // Unready operands send the op back to the scheduler
        replayValid = update && !pipeReg.dataValid;
        replayOp = pipeReg.op;
    end

endmodule

// File: design/intRegFile.sv
// ============================================================
// Physical register file with 32 entries
// Reads are combinational and see the old value on a write
// ============================================================
module intRegFile (
    input  logic ctrl,
    input  logic rst,
    input  logic [intOpPkg::regNumWidth-1:0] rdNum1,
    input  logic [intOpPkg::regNumWidth-1:0] rdNum2,
    input  logic writeEn,
    input  logic [intOpPkg::regNumWidth-1:0] writeNum,
    input  logic [intOpPkg::dataWidth-1:0] writeData,
    input  logic [intOpPkg::regNumWidth-1:0] archNum,
    output logic [intOpPkg::dataWidth-1:0] rdData1,
    output logic [intOpPkg::dataWidth-1:0] rdData2,
    output logic [intOpPkg::dataWidth-1:0] archData
);
    import intOpPkg::*;

    localparam int regCount = 2 ** regNumWidth;

    logic [dataWidth-1:0] regs [regCount];

    // All registers start at zero
    always_ff @(posedge ctrl) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeNum] <= writeData;
        end
    end

    // Operand ports for the execution stage
    assign rdData1 = regs[rdNum1];
    assign rdData2 = regs[rdNum2];

    // Commit side view
    assign archData = regs[archNum];

endmodule

// File: design/completionTable.sv
// ============================================================
// Per-tag execution state and address storage
// Completion write wins over allocation on the same tag
// Stored address is the fault address on a fault, else op pc
// ============================================================
module completionTable (
    input  logic ctrl,
    input  logic rst,
    input  logic allocValid,
    input  logic [intOpPkg::tagWidth-1:0] allocTag,
    input  logic [intOpPkg::tagWidth-1:0] statusTag,
    output intOpPkg::ExecState statusState,
    output logic [intOpPkg::dataWidth-1:0] statusAddr,
    completionIf.tableSide completion
);
    import intOpPkg::*;

    localparam int entryCount = 2 ** tagWidth;

    ExecState states [entryCount];
    logic [dataWidth-1:0] addrs [entryCount];
    logic [dataWidth-1:0] writeAddr;

    assign writeAddr = (completion.state == FAULT_MISALIGNED) ?
        completion.faultAddr : completion.pc;

    // Later assignment takes priority on a tag collision
    always_ff @(posedge ctrl) begin
        if (rst) begin
            for (int i = 0; i < entryCount; i++) begin
                states[i] <= NOT_FINISHED;
            end
        end else begin
            if (allocValid) begin
                states[allocTag] <= NOT_FINISHED;
            end
            if (completion.write) begin
                states[completion.tag] <= completion.state;
            end
        end
    end

    always_ff @(posedge ctrl) begin
        if (allocValid) begin
            addrs[allocTag] <= '0;
        end
        if (completion.write) begin
            addrs[completion.tag] <= writeAddr;
        end
    end

    // Status lookup
    assign statusState = states[statusTag];
    assign statusAddr = addrs[statusTag];

endmodule

// File: design/intBackEnd.sv
// ============================================================
// Integer back end slice, single issue
// Scheduler starts with queueDepth credits and issues only
// while it holds one
// ============================================================
module intBackEnd #(
    parameter int queueDepth = 4
) (
    input  logic ctrl,
    input  logic rst,
    input  logic stall,
    input  logic issueValid,
    input  intPipePkg::IntIssueOp issueOp,
    input  logic flushActive,
    input  logic [intOpPkg::tagWidth-1:0] flushHead,
    input  logic [intOpPkg::tagWidth-1:0] flushTail,
    input  logic [intOpPkg::regNumWidth-1:0] archNum,
    input  logic [intOpPkg::tagWidth-1:0] statusTag,
    output logic creditReturn,
    output logic brValid,
    output logic brTaken,
    output logic [intOpPkg::dataWidth-1:0] brTarget,
    output logic brMisPred,
    output logic replayValid,
    output logic [intOpPkg::tagWidth-1:0] replayTag,
    output logic [intOpPkg::dataWidth-1:0] archData,
    output intOpPkg::ExecState statusState,
    output logic [intOpPkg::dataWidth-1:0] statusAddr
);
    import intOpPkg::*;
    import intPipePkg::*;

    logic [regNumWidth-1:0] rdNum1;
    logic [regNumWidth-1:0] rdNum2;
    logic [dataWidth-1:0] rdData1;
    logic [dataWidth-1:0] rdData2;
    logic regWe;
    logic [regNumWidth-1:0] regNum;
    logic [dataWidth-1:0] regData;
    ExecResult execResult;
    BranchResult brResult;
    IntIssueOp replayOp;

    completionIf completion ();

    intExecStage #(
        .queueDepth(queueDepth)
    ) execStage (
        .ctrl(ctrl),
        .rst(rst),
        .stall(stall),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .rdNum1(rdNum1),
        .rdNum2(rdNum2),
        .rdData1(rdData1),
        .rdData2(rdData2),
        .wbEn(regWe),
        .wbNum(regNum),
        .wbData(regData),
        .execOut(execResult)
    );

    intRegWriteStage writeStage (
        .ctrl(ctrl),
        .rst(rst),
        .stall(stall),
        .execIn(execResult),
        .flushActive(flushActive),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .regWe(regWe),
        .regNum(regNum),
        .regData(regData),
        .creditReturn(creditReturn),
        .brOut(brResult),
        .replayValid(replayValid),
        .replayOp(replayOp),
        .completion(completion.writer)
    );

    intRegFile regFile (
        .ctrl(ctrl),
        .rst(rst),
        .rdNum1(rdNum1),
        .rdNum2(rdNum2),
        .writeEn(regWe),
        .writeNum(regNum),
        .writeData(regData),
        .archNum(archNum),
        .rdData1(rdData1),
        .rdData2(rdData2),
        .archData(archData)
    );

    // Entry is cleared as the op is accepted
    completionTable compTable (
        .ctrl(ctrl),
        .rst(rst),
        .allocValid(issueValid),
        .allocTag(issueOp.tag),
        .statusTag(statusTag),
        .statusState(statusState),
        .statusAddr(statusAddr),
        .completion(completion.tableSide)
    );

    assign brValid = brResult.valid;
    assign brTaken = brResult.taken;
    assign brTarget = brResult.nextAddr;
    assign brMisPred = brResult.misPred;
    assign replayTag = replayOp.tag;

endmodule

// File: verif/intBackEnd_chk.sv
// ============================================================
// Bound rule checks on credits and register writes
// Outstanding count starts at zero after reset
// ============================================================
module intBackEnd_chk #(
    parameter int queueDepth = 4
) (
    input logic ctrl,
    input logic rst,
    input logic stall,
    input logic issueValid,
    input logic creditReturn,
    input logic regWe
);
    int outstanding;

    // Ops accepted minus ops that have left the write stage
    always_ff @(posedge ctrl) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(issueValid) - int'(creditReturn);
        end
    end

    assert property (@(posedge ctrl) disable iff (rst)
        creditReturn |-> !stall && (outstanding > 0))
        else $error("credit returned while stalled or with no op outstanding");

    assert property (@(posedge ctrl) disable iff (rst)
        regWe |-> creditReturn && (outstanding > 0))
        else $error("register write without a credit return of an issued op");

    assert property (@(posedge ctrl) disable iff (rst) outstanding <= queueDepth + 2)
        else $error("too many ops outstanding");

endmodule

// File: verif/intBackEndTb.sv
// ============================================================
// Random single-issue traffic checked against a sequential model
// Flush ranges always end at the last op of their batch
// Scheduler starts each run with queueDepth credits
// ============================================================
module intBackEndTb;
    import intOpPkg::*;
    import intPipePkg::*;

    localparam int queueDepth = 4;
    localparam int batchCount = 25;
    localparam int maxOps = 14;
    localparam int timeoutCycles = batchCount * maxOps * 10 + 500;

    typedef struct packed {
        logic taken;
        logic [31:0] target;
        logic misPred;
    } BranchExp;

    logic ctrl = 1'b0;
    logic rst;
    logic stall;
    logic issueValid;
    IntIssueOp issueOp;
    logic flushActive;
    logic [tagWidth-1:0] flushHead;
    logic [tagWidth-1:0] flushTail;
    logic [regNumWidth-1:0] archNum;
    logic [tagWidth-1:0] statusTag;
    logic creditReturn;
    logic brValid;
    logic brTaken;
    logic [dataWidth-1:0] brTarget;
    logic brMisPred;
    logic replayValid;
    logic [tagWidth-1:0] replayTag;
    logic [dataWidth-1:0] archData;
    ExecState statusState;
    logic [dataWidth-1:0] statusAddr;

    // Model state
    logic [31:0] lfsrState;
    logic [31:0] modelRegs [32];
    ExecState expState [16];
    logic [31:0] expAddr [16];
    BranchExp brQueue [$];
    logic [3:0] replayQueue [$];
    logic [3:0] nextTag;
    int issuedCount;
    int returnedCount;
    int cycleCount;

    intBackEnd #(
        .queueDepth(queueDepth)
    ) u_dut (
        .ctrl(ctrl),
        .rst(rst),
        .stall(stall),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .flushActive(flushActive),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .archNum(archNum),
        .statusTag(statusTag),
        .creditReturn(creditReturn),
        .brValid(brValid),
        .brTaken(brTaken),
        .brTarget(brTarget),
        .brMisPred(brMisPred),
        .replayValid(replayValid),
        .replayTag(replayTag),
        .archData(archData),
        .statusState(statusState),
        .statusAddr(statusAddr)
    );

    bind intBackEnd intBackEnd_chk #(
        .queueDepth(queueDepth)
    ) ruleCheck (
        .ctrl(ctrl),
        .rst(rst),
        .stall(stall),
        .issueValid(issueValid),
        .creditReturn(creditReturn),
        .regWe(regWe)
    );

    always #5 ctrl = ~ctrl;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic failNow(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    function automatic logic randStall();
        return randBits(2) == 32'd3;
    endfunction

    task automatic makeOp(output IntIssueOp op);
        logic [2:0] kind;
        logic [11:0] immLow;
        op = '0;
        kind = 3'(randBits(3));
        if (kind > 3'd5) begin
            op.opType = RIJ;
        end else begin
            op.opType = IntOpType'(kind);
        end
        op.tag = nextTag;
        nextTag = nextTag + 4'd1;
        op.pc = {14'd0, 16'(randBits(16)), 2'b00};
        // Few registers so that hazards are common
        op.src1Num = 5'(randBits(3));
        op.src2Num = 5'(randBits(3));
        op.dstNum = 5'(randBits(3));
        op.writeReg = randBits(2) != 32'd0;
        immLow = 12'(randBits(12));
        op.imm = {{20{immLow[11]}}, immLow};
        if (randBits(1) != 32'd0) begin
            op.imm[1:0] = 2'b00;
        end
        op.predTaken = randBits(1) == 32'd1;
        op.operandsReady = randBits(3) != 32'd0;
    endtask

    // Sequential execution in issue order
    task automatic modelOp(input IntIssueOp op, input logic flushed);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] link;
        logic [31:0] target;
        logic taken;
        logic isBranch;
        logic misPred;
        a = modelRegs[op.src1Num];
        b = modelRegs[op.src2Num];
        link = op.pc + 32'd4;
        isBranch = (op.opType == BR) || (op.opType == RIJ);
        taken = 1'b0;
        target = '0;
        if (op.opType == BR) begin
            taken = (a == b);
            target = taken ? (op.pc + op.imm) : link;
        end else if (op.opType == RIJ) begin
            taken = 1'b1;
            target = a + op.imm;
        end
        misPred = isBranch && (taken != op.predTaken);
        expState[op.tag] = NOT_FINISHED;
        if (flushed) begin
            return;
        end
        if (!op.operandsReady) begin
            replayQueue.push_back(op.tag);
            return;
        end
        if (isBranch) begin
            brQueue.push_back(BranchExp'{taken, target, misPred});
            if (target[1:0] != 2'b00) begin
                expState[op.tag] = FAULT_MISALIGNED;
                expAddr[op.tag] = target;
            end else begin
                expState[op.tag] = misPred ? REFETCH_NEXT : SUCCESS;
                expAddr[op.tag] = op.pc;
            end
            if (op.opType == RIJ && op.writeReg) begin
                modelRegs[op.dstNum] = link;
            end
        end else begin
            expState[op.tag] = SUCCESS;
            expAddr[op.tag] = op.pc;
            if (op.writeReg) begin
                case (op.opType)
                    ADD: modelRegs[op.dstNum] = a + b;
                    SUB: modelRegs[op.dstNum] = a - b;
                    AND: modelRegs[op.dstNum] = a & b;
                    default: modelRegs[op.dstNum] = a ^ b;
                endcase
            end
        end
    endtask

    task automatic runBatch();
        int count;
        int sent;
        int flushFrom;
        logic useFlush;
        IntIssueOp op;
        count = int'(randBits(4) % 32'd14) + 1;
        useFlush = randBits(2) == 32'd3;
        flushFrom = int'(randBits(4)) % count;
        @(posedge ctrl);
        flushActive <= useFlush;
        flushHead <= nextTag + 4'(flushFrom);
        flushTail <= nextTag + 4'(count - 1);
        sent = 0;
        while (sent < count) begin
            @(posedge ctrl);
            stall <= randStall();
            if ((issuedCount - returnedCount < queueDepth) && (randBits(2) != 32'd0)) begin
                makeOp(op);
                modelOp(op, useFlush && (sent >= flushFrom));
                issueValid <= 1'b1;
                issueOp <= op;
                issuedCount++;
                sent++;
            end else begin
                issueValid <= 1'b0;
            end
        end
        @(posedge ctrl);
        issueValid <= 1'b0;
        // Drain until every credit is back
        while (returnedCount != issuedCount) begin
            @(posedge ctrl);
            stall <= randStall();
        end
        @(posedge ctrl);
        stall <= 1'b0;
        flushActive <= 1'b0;
        check(32'(brQueue.size()), 32'd0, "branch results missing after drain");
        check(32'(replayQueue.size()), 32'd0, "replays missing after drain");
        // Sweep architectural registers and completion table
        for (int i = 0; i < 32; i++) begin
            @(posedge ctrl);
            archNum <= 5'(i);
            statusTag <= 4'(i);
            @(negedge ctrl);
            check(archData, modelRegs[i], $sformatf("register %0d", i));
            if (i < 16) begin
                check(32'(statusState), 32'(expState[i]), $sformatf("state of tag %0d", i));
                if (expState[i] != NOT_FINISHED) begin
                    check(statusAddr, expAddr[i], $sformatf("address of tag %0d", i));
                end
            end
        end
    endtask

    // Outputs are sampled mid-cycle where they are stable
    always @(negedge ctrl) begin
        BranchExp e;
        logic [3:0] expTag;
        if (!rst) begin
            if (creditReturn) begin
                if (returnedCount >= issuedCount) begin
                    failNow("Credit returned with no op outstanding");
                end else begin
                    returnedCount++;
                end
            end
            if (brValid) begin
                if (brQueue.size() == 0) begin
                    failNow("Branch result seen with no branch expected");
                end else begin
                    e = brQueue.pop_front();
                    check(32'(brTaken), 32'(e.taken), "branch taken");
                    check(brTarget, e.target, "branch target");
                    check(32'(brMisPred), 32'(e.misPred), "branch mispredict");
                end
            end
            if (replayValid) begin
                if (replayQueue.size() == 0) begin
                    failNow("Replay seen with no replay expected");
                end else begin
                    expTag = replayQueue.pop_front();
                    check(32'(replayTag), 32'(expTag), "replay tag");
                end
            end
        end
    end

    always @(posedge ctrl) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            failNow("Timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        lfsrState = 32'he5d0_03d4;
        rst = 1'b1;
        stall = 1'b0;
        issueValid = 1'b0;
        issueOp = '0;
        flushActive = 1'b0;
        flushHead = '0;
        flushTail = '0;
        archNum = '0;
        statusTag = '0;
        nextTag = '0;
        issuedCount = 0;
        returnedCount = 0;
        cycleCount = 0;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        for (int t = 0; t < 16; t++) begin
            expState[t] = NOT_FINISHED;
            expAddr[t] = '0;
        end
        repeat (8) @(posedge ctrl);
        rst <= 1'b0;
        for (int b = 0; b < batchCount; b++) begin
            runBatch();
        end
        check(32'(returnedCount), 32'(issuedCount), "credits returned");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: compile.f
design/intOpPkg.sv
design/intPipePkg.sv
design/completionIf.sv
design/intExecStage.sv
design/intRegWriteStage.sv
design/intRegFile.sv
design/completionTable.sv
design/intBackEnd.sv
verif/intBackEnd_chk.sv
verif/intBackEndTb.sv

// File: Makefile
# Verilator build and run of the integer back end testbench
SRCS := $(shell cat compile.f)

run: obj_dir/VintBackEndTb
	@out=$$(./obj_dir/VintBackEndTb); echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

obj_dir/VintBackEndTb: compile.f $(SRCS)
	verilator --binary --assert --top-module intBackEndTb -f compile.f -o VintBackEndTb

clean:
	rm -rf obj_dir

.PHONY: run clean
